//--- src/adc_pkg.sv
// ADC sample path shared definitions
`default_nettype none

package adc_pkg;

  //////////////////////
  // widths and depths
  //////////////////////

  localparam int ADC_DW     = 14;  // sample width
  localparam int ADC_CHN    = 4;   // channels per frame
  localparam int FIFO_DEPTH = 16;  // frames
  localparam int FIFO_AW    = 4;   // log2 of depth
  localparam int APB_AW     = 8;
  localparam int PDM_RNG    = 255; // pdm period minus one

  typedef logic        [ADC_DW-1:0]  adc_raw_t;   // unsigned, negative slope
  typedef logic signed [ADC_DW-1:0]  adc_smp_t;   // two's complement
  typedef adc_smp_t    [ADC_CHN-1:0] adc_frame_t; // ch0 in low bits
  typedef logic        [FIFO_AW:0]   fifo_lvl_t;  // 0..FIFO_DEPTH
  typedef logic        [APB_AW-1:0]  apb_addr_t;
  typedef logic        [31:0]        apb_data_t;
  typedef logic        [7:0]         pdm_cfg_t;

  //////////////////////
  // register map
  //////////////////////

  localparam apb_addr_t REG_CTRL  = 8'h00; // bit 0 acquisition enable
  localparam apb_addr_t REG_STAT  = 8'h04; // level, overflow
  localparam apb_addr_t REG_DAT01 = 8'h08; // ch1:ch0
  localparam apb_addr_t REG_DAT23 = 8'h0C; // ch3:ch2, read pops
  localparam apb_addr_t REG_PDM0  = 8'h10;
  localparam apb_addr_t REG_PDM1  = 8'h14;
  localparam apb_addr_t REG_PDM2  = 8'h18;
  localparam apb_addr_t REG_PDM3  = 8'h1C;

  localparam int STAT_OVF_BIT = 8; // w1c in REG_STAT

endpackage

`default_nettype wire

//--- src/adc_capture.sv
// ADC capture and format conversion
`timescale 1ns/1ps
`default_nettype none

module adc_capture import adc_pkg::*; (
  input  logic                     adc_clk_01,
  input  logic                     rst_n_i,
  input  adc_raw_t [ADC_CHN-1:0]   adc_dat_i,  // raw words, all channels
  input  logic                     enable_i,   // acquisition on
  output logic                     push_o,     // frame valid toward fifo
  output adc_frame_t               frame_o
);

  //////////////////////
  // conversion
  //////////////////////

  // negative slope unsigned to two's complement
  // msb stays, the rest flips
  function automatic adc_smp_t conv(input adc_raw_t raw);
    return {raw[ADC_DW-1], ~raw[ADC_DW-2:0]};
  endfunction

  adc_frame_t conv_r;  // first stage
  logic       vld_r;   // enable seen with the first stage

  //////////////////////
  // data pipeline
  //////////////////////

  // sample data through two stages
  always_ff @(posedge adc_clk_01) begin
    for (int i = 0; i < ADC_CHN; i++) begin
      conv_r[i] <= conv(adc_dat_i[i]);  // stage 1
    end
    frame_o <= conv_r;                  // stage 2
  end

  // valid follows data through both stages
  always_ff @(posedge adc_clk_01 or negedge rst_n_i) begin
    if (!rst_n_i) begin
      vld_r  <= 1'b0;
      push_o <= 1'b0;
    end else begin
      vld_r  <= enable_i;
      push_o <= vld_r;  // lands in fifo on the next edge
    end
  end

  //////////////////////
  // checks
  //////////////////////

  // two stages of latency, so no frame right after enabling
  a_push_latency: assert property (
    @(posedge adc_clk_01) disable iff (!rst_n_i)
    $rose(enable_i) |=> !push_o
  ) else $error("push_o high too soon after enable_i rose");

endmodule

`default_nettype wire

//--- src/sample_fifo.sv
// frame FIFO with level and overflow
`timescale 1ns/1ps
`default_nettype none

module sample_fifo import adc_pkg::*; (
  input  logic        adc_clk_01,
  input  logic        rst_n_i,
  // write side
  input  logic        push_i,
  input  adc_frame_t  frame_i,
  output logic        full_o,
  // read side
  input  logic        pop_i,
  output adc_frame_t  frame_o,    // head frame
  output logic        empty_o,
  output fifo_lvl_t   level_o,
  // overflow
  output logic        ovf_o,      // sticky
  input  logic        ovf_clr_i
);

  adc_frame_t         mem [FIFO_DEPTH];
  logic [FIFO_AW-1:0] wr_ptr;
  logic [FIFO_AW-1:0] rd_ptr;
  fifo_lvl_t          level_q;
  logic               push_ok;
  logic               pop_ok;

  assign full_o  = (level_q == fifo_lvl_t'(FIFO_DEPTH));
  assign empty_o = (level_q == '0);
  assign level_o = level_q;

  assign push_ok = push_i & ~full_o;   // dropped when full
  assign pop_ok  = pop_i  & ~empty_o;

  //////////////////////
  // storage
  //////////////////////

  always_ff @(posedge adc_clk_01) begin
    if (push_ok) begin
      mem[wr_ptr] <= frame_i;
    end
  end

  assign frame_o = mem[rd_ptr];  // visible the cycle after push

  //////////////////////
  // pointers and level
  //////////////////////

  always_ff @(posedge adc_clk_01 or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      level_q <= '0;
    end else begin
      if (push_ok) wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
      if (pop_ok)  rd_ptr <= rd_ptr + 1'b1;
      case ({push_ok, pop_ok})
        2'b10:   level_q <= level_q + 1'b1;
        2'b01:   level_q <= level_q - 1'b1;
        default: level_q <= level_q;         // neither or both at once
      endcase
    end
  end

  // set wins over clear on overflow
  always_ff @(posedge adc_clk_01 or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ovf_o <= 1'b0;
    end else if (push_i && full_o) begin
      ovf_o <= 1'b1;  // frame lost
    end else if (ovf_clr_i) begin
      ovf_o <= 1'b0;
    end
  end

  //////////////////////
  // checks
  //////////////////////

  a_level_max: assert property (
    @(posedge adc_clk_01) disable iff (!rst_n_i)
    level_o <= fifo_lvl_t'(FIFO_DEPTH)
  ) else $error("fifo level above depth");

  // register block must never pop an empty fifo
  a_no_pop_empty: assert property (
    @(posedge adc_clk_01) disable iff (!rst_n_i)
    !(pop_i && empty_o)
  ) else $error("pop while fifo empty");

endmodule

`default_nettype wire

//--- src/apb_regs.sv
// APB register block
`timescale 1ns/1ps
`default_nettype none

module apb_regs import adc_pkg::*; (
  input  logic            adc_clk_01,
  input  logic            rst_n_i,
  // APB slave
  input  logic            psel_i,
  input  logic            penable_i,
  input  logic            pwrite_i,
  input  apb_addr_t       paddr_i,
  input  apb_data_t       pwdata_i,
  output apb_data_t       prdata_o,
  output logic            pready_o,
  output logic            pslverr_o,
  // acquisition and fifo
  output logic            enable_o,
  output logic            pop_o,      // one cycle per DAT23 read
  output logic            ovf_clr_o,
  input  adc_frame_t      frame_i,    // fifo head
  input  logic            empty_i,
  input  fifo_lvl_t       level_i,
  input  logic            ovf_i,
  // pdm duty values
  output pdm_cfg_t [3:0]  pdm_cfg_o
);

  logic           access;    // second phase of a transfer
  logic           wr_en;
  logic           err;
  apb_data_t      rdata;
  logic           enable_q;
  pdm_cfg_t [3:0] pdm_cfg_q;

  // 14 bit sample into a 16 bit half word
  function automatic logic [15:0] sext16(input adc_smp_t s);
    return {{(16-ADC_DW){s[ADC_DW-1]}}, s};
  endfunction

  assign access = psel_i & penable_i;
  assign wr_en  = access & pwrite_i;

  //////////////////////
  // read decode
  //////////////////////

  always_comb begin
    rdata = '0;
    err   = 1'b0;
    case (paddr_i)
      REG_CTRL: rdata[0] = enable_q;
      REG_STAT: begin
        rdata[FIFO_AW:0]    = level_i;
        rdata[STAT_OVF_BIT] = ovf_i;
      end
      REG_DAT01: begin
        if (!pwrite_i && empty_i) err = 1'b1;  // nothing to read
        else rdata = {sext16(frame_i[1]), sext16(frame_i[0])};
      end
      REG_DAT23: begin
        if (!pwrite_i && empty_i) err = 1'b1;
        else rdata = {sext16(frame_i[3]), sext16(frame_i[2])};
      end
      REG_PDM0, REG_PDM1, REG_PDM2, REG_PDM3: begin
        rdata[7:0] = pdm_cfg_q[paddr_i[3:2]];  // word index picks channel
      end
      default: err = 1'b1;  // unmapped
    endcase
  end

  // no wait states
  assign pready_o  = access;
  assign pslverr_o = access & err;
  assign prdata_o  = err ? '0 : rdata;  // erroring read gives 0

  // pop and clear act on the edge closing the access phase
  assign pop_o     = access & ~pwrite_i & ~err & (paddr_i == REG_DAT23);
  assign ovf_clr_o = wr_en & (paddr_i == REG_STAT) & pwdata_i[STAT_OVF_BIT];

  //////////////////////
  // write registers
  //////////////////////

  always_ff @(posedge adc_clk_01 or negedge rst_n_i) begin
    if (!rst_n_i) begin
      enable_q  <= 1'b0;
      pdm_cfg_q <= '0;
    end else if (wr_en) begin
      case (paddr_i)
        REG_CTRL: enable_q <= pwdata_i[0];
        REG_PDM0, REG_PDM1, REG_PDM2, REG_PDM3: begin
          pdm_cfg_q[paddr_i[3:2]] <= pwdata_i[7:0];
        end
        default: ;  // STAT handled by ovf_clr_o, data regs read only
      endcase
    end
  end

  assign enable_o  = enable_q;
  assign pdm_cfg_o = pdm_cfg_q;

  //////////////////////
  // checks
  //////////////////////

  // access phase always follows a selected setup phase
  a_apb_phase: assert property (
    @(posedge adc_clk_01) disable iff (!rst_n_i)
    penable_i |-> $past(psel_i)
  ) else $error("penable_i without psel_i in previous cycle");

endmodule

`default_nettype wire

//--- src/pdm_dac.sv
// PDM analog outputs
`timescale 1ns/1ps
`default_nettype none

module pdm_dac import adc_pkg::*; (
  input  logic           adc_clk_01,
  input  logic           rst_n_i,
  input  pdm_cfg_t [3:0] cfg_i,   // ones per PDM_RNG+1 cycles
  output logic     [3:0] pdm_o
);

  //////////////////////
  // one accumulator per channel
  //////////////////////

  for (genvar c = 0; c < 4; c++) begin : g_ch
    pdm_cfg_t   acc_q;
    logic [8:0] sum;      // one extra bit for the carry
    logic       carry;

    assign sum   = {1'b0, acc_q} + {1'b0, cfg_i[c]};
    assign carry = (sum > 9'(PDM_RNG));

    always_ff @(posedge adc_clk_01 or negedge rst_n_i) begin
      if (!rst_n_i) begin
        acc_q    <= '0;
        pdm_o[c] <= 1'b0;
      end else begin
        acc_q    <= sum[7:0];  // wraps at range
        pdm_o[c] <= carry;     // exactly cfg ones per period
      end
    end
  end

endmodule

`default_nettype wire

//--- src/adc_top.sv
// four channel ADC sample path top
`timescale 1ns/1ps
`default_nettype none

module adc_top import adc_pkg::*; (
  input  logic                    adc_clk_01,
  input  logic                    rst_n_i,
  // ADC
  input  adc_raw_t [ADC_CHN-1:0]  adc_dat_i,
  // APB slave
  input  logic                    psel_i,
  input  logic                    penable_i,
  input  logic                    pwrite_i,
  input  apb_addr_t               paddr_i,
  input  apb_data_t               pwdata_i,
  output apb_data_t               prdata_o,
  output logic                    pready_o,
  output logic                    pslverr_o,
  // PDM outputs
  output logic [3:0]              pdm_o
);

  //////////////////////
  // local signals
  //////////////////////

  logic           acq_en;     // from REG_CTRL
  logic           push;
  adc_frame_t     cap_frame;  // capture to fifo
  adc_frame_t     head_frame; // fifo to regs
  logic           pop;
  logic           empty;
  fifo_lvl_t      level;
  logic           ovf;
  logic           ovf_clr;
  pdm_cfg_t [3:0] pdm_cfg;

  //////////////////////
  // sample path
  //////////////////////

  adc_capture capture_i (
    .adc_clk_01 (adc_clk_01),
    .rst_n_i    (rst_n_i   ),
    .adc_dat_i  (adc_dat_i ),
    .enable_i   (acq_en    ),
    .push_o     (push      ),
    .frame_o    (cap_frame )
  );

  sample_fifo fifo_i (
    .adc_clk_01 (adc_clk_01),
    .rst_n_i    (rst_n_i   ),
    .push_i     (push      ),
    .frame_i    (cap_frame ),
    .full_o     (          ),  // no back-pressure toward the ADC
    .pop_i      (pop       ),
    .frame_o    (head_frame),
    .empty_o    (empty     ),
    .level_o    (level     ),
    .ovf_o      (ovf       ),
    .ovf_clr_i  (ovf_clr   )
  );

  //////////////////////
  // host side
  //////////////////////

  apb_regs regs_i (
    .adc_clk_01 (adc_clk_01),
    .rst_n_i    (rst_n_i   ),
    .psel_i     (psel_i    ),
    .penable_i  (penable_i ),
    .pwrite_i   (pwrite_i  ),
    .paddr_i    (paddr_i   ),
    .pwdata_i   (pwdata_i  ),
    .prdata_o   (prdata_o  ),
    .pready_o   (pready_o  ),
    .pslverr_o  (pslverr_o ),
    .enable_o   (acq_en    ),
    .pop_o      (pop       ),
    .ovf_clr_o  (ovf_clr   ),
    .frame_i    (head_frame),
    .empty_i    (empty     ),
    .level_i    (level     ),
    .ovf_i      (ovf       ),
    .pdm_cfg_o  (pdm_cfg   )
  );

  pdm_dac pdm_i (
    .adc_clk_01 (adc_clk_01),
    .rst_n_i    (rst_n_i   ),
    .cfg_i      (pdm_cfg   ),
    .pdm_o      (pdm_o     )
  );

endmodule

`default_nettype wire

//--- include/adc_tb_tasks.svh
// testbench bus, compare and test tasks
`ifndef ADC_TB_TASKS_SVH
`define ADC_TB_TASKS_SVH
`default_nettype none

////////////////////
// compare tasks
////////////////////

task automatic check_data(input string name, input apb_data_t exp, input apb_data_t act);
  n_chk++;
  if (act !== exp) begin
    n_err_val++;
    $display("** Error at %0t: %s expected 0x%08h, got 0x%08h", $time, name, exp, act);
  end
endtask

task automatic check_smp(input string name, input adc_smp_t exp, input adc_smp_t act);
  n_chk++;
  if (act !== exp) begin
    n_err_val++;
    $display("** Error at %0t: %s expected %0d, got %0d", $time, name, exp, act);
  end
endtask

task automatic check_lvl(input string name, input fifo_lvl_t exp, input fifo_lvl_t act);
  n_chk++;
  if (act !== exp) begin
    n_err_val++;
    $display("** Error at %0t: %s expected %0d, got %0d", $time, name, exp, act);
  end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
  n_chk++;
  if (act !== exp) begin
    n_err_val++;
    $display("** Error at %0t: %s expected %b, got %b", $time, name, exp, act);
  end
endtask

////////////////////
// APB driver
////////////////////

// setup, access, then one idle cycle
task automatic apb_xfer(input logic wr, input apb_addr_t addr, input apb_data_t wdata,
                        output apb_data_t rdata, output logic err);
  @(negedge adc_clk_01);
  psel_i   = 1'b1;
  pwrite_i = wr;
  paddr_i  = addr;
  pwdata_i = wdata;
  @(negedge adc_clk_01);
  penable_i = 1'b1;
  #1;  // read data settles well before the closing edge
  check_bit("pready_o", 1'b1, pready_o);
  rdata = prdata_o;
  err   = pslverr_o;
  @(negedge adc_clk_01);
  psel_i    = 1'b0;
  penable_i = 1'b0;
endtask

task automatic apb_write(input apb_addr_t addr, input apb_data_t wdata);
  apb_data_t rd;
  logic      err;
  apb_xfer(1'b1, addr, wdata, rd, err);
  check_bit("pslverr_o", 1'b0, err);
endtask

task automatic read_expect(input apb_addr_t addr, input string name, input apb_data_t exp);
  apb_data_t rd;
  logic      err;
  apb_xfer(1'b0, addr, '0, rd, err);
  check_bit("pslverr_o", 1'b0, err);
  check_data(name, exp, rd);
endtask

////////////////////
// reference model
////////////////////

// lower 13 bits flip in negative slope coding
function automatic adc_frame_t conv_frame(input raw_frame_t raw);
  adc_frame_t f;
  for (int c = 0; c < ADC_CHN; c++) f[c] = adc_smp_t'(raw[c] ^ 14'h1FFF);
  return f;
endfunction

function automatic apb_data_t half_pair(input adc_smp_t hi, input adc_smp_t lo);
  return {{(16-ADC_DW){hi[ADC_DW-1]}}, hi, {(16-ADC_DW){lo[ADC_DW-1]}}, lo};
endfunction

function automatic adc_frame_t frame_of(input apb_data_t w01, input apb_data_t w23);
  adc_frame_t f;
  f[0] = w01[ADC_DW-1:0];
  f[1] = w01[16+ADC_DW-1:16];
  f[2] = w23[ADC_DW-1:0];
  f[3] = w23[16+ADC_DW-1:16];
  return f;
endfunction

////////////////////
// directed tests
////////////////////

task automatic test_reset_values();
  read_expect(REG_CTRL, "REG_CTRL", '0);
  read_expect(REG_STAT, "REG_STAT", '0);
  for (int c = 0; c < 4; c++) read_expect(apb_addr_t'(REG_PDM0 + 4*c), "REG_PDMn", '0);
  check_data("pdm_o", '0, apb_data_t'(pdm_o));
endtask

task automatic test_capture_order();
  raw_frame_t raw_q[$];
  apb_data_t  w01_q[$];
  apb_data_t  w23_q[$];
  raw_frame_t rf;
  apb_data_t  rd;
  logic       err;
  adc_frame_t got;
  adc_frame_t exp;
  int         start;
  int         n;
  apb_write(REG_CTRL, 32'h1);
  for (int i = 0; i < FIFO_DEPTH + 8; i++) begin  // longer than the FIFO
    for (int c = 0; c < ADC_CHN; c++) rf[c] = adc_raw_t'($urandom);
    adc_dat_i = rf;
    raw_q.push_back(rf);
    @(negedge adc_clk_01);
  end
  apb_write(REG_CTRL, 32'h0);
  repeat (4) @(negedge adc_clk_01);  // pipeline drains
  apb_xfer(1'b0, REG_STAT, '0, rd, err);
  check_lvl("level_o", fifo_lvl_t'(FIFO_DEPTH), rd[FIFO_AW:0]);
  n = int'(rd[FIFO_AW:0]);
  for (int i = 0; i < n; i++) begin
    apb_xfer(1'b0, REG_DAT01, '0, rd, err);
    w01_q.push_back(rd);
    apb_xfer(1'b0, REG_DAT23, '0, rd, err);  // pops
    w23_q.push_back(rd);
  end
  start = -1;
  if (n > 0) begin
    got = frame_of(w01_q[0], w23_q[0]);
    foreach (raw_q[i]) if (start < 0 && conv_frame(raw_q[i]) == got) start = i;
  end
  if (start < 0 || start + n > raw_q.size()) begin
    n_err_oth++;
    $display("popped frames do not line up with the driven frames (start %0d)", start);
  end else begin
    for (int i = 0; i < n; i++) begin
      exp = conv_frame(raw_q[start + i]);
      got = frame_of(w01_q[i], w23_q[i]);
      for (int c = 0; c < ADC_CHN; c++) begin
        check_smp($sformatf("frame %0d ch%0d", i, c), exp[c], got[c]);
      end
      check_data("REG_DAT01", half_pair(exp[1], exp[0]), w01_q[i]);
      check_data("REG_DAT23", half_pair(exp[3], exp[2]), w23_q[i]);
    end
  end
  apb_write(REG_STAT, 32'h100);  // drop the overflow from this run
  read_expect(REG_STAT, "REG_STAT", '0);
endtask

task automatic test_level_overflow();
  apb_data_t rd;
  logic      err;
  apb_write(REG_CTRL, 32'h1);
  repeat (FIFO_DEPTH + 8) @(negedge adc_clk_01);
  apb_write(REG_CTRL, 32'h0);
  repeat (4) @(negedge adc_clk_01);
  apb_xfer(1'b0, REG_STAT, '0, rd, err);
  check_lvl("level_o", fifo_lvl_t'(FIFO_DEPTH), rd[FIFO_AW:0]);
  check_bit("ovf_o", 1'b1, rd[STAT_OVF_BIT]);
  apb_write(REG_STAT, 32'h100);  // w1c
  apb_xfer(1'b0, REG_STAT, '0, rd, err);
  check_lvl("level_o", fifo_lvl_t'(FIFO_DEPTH), rd[FIFO_AW:0]);
  check_bit("ovf_o", 1'b0, rd[STAT_OVF_BIT]);
endtask

// FIFO starts full here
task automatic test_apb_errors();
  apb_data_t rd;
  logic      err;
  apb_xfer(1'b0, 8'h20, '0, rd, err);  // unmapped
  check_bit("pslverr_o", 1'b1, err);
  check_data("prdata_o", '0, rd);
  apb_xfer(1'b0, REG_STAT, '0, rd, err);
  check_lvl("level_o", fifo_lvl_t'(FIFO_DEPTH), rd[FIFO_AW:0]);
  repeat (FIFO_DEPTH) apb_xfer(1'b0, REG_DAT23, '0, rd, err);
  apb_xfer(1'b0, REG_DAT23, '0, rd, err);  // now empty
  check_bit("pslverr_o", 1'b1, err);
  check_data("prdata_o", '0, rd);
  apb_xfer(1'b0, REG_STAT, '0, rd, err);
  check_lvl("level_o", '0, rd[FIFO_AW:0]);
endtask

task automatic test_pdm_density();
  pdm_cfg_t val[4] = '{8'h25, 8'h80, 8'hC3, 8'hFF};
  int       cnt[4] = '{default: 0};
  for (int c = 0; c < 4; c++) apb_write(apb_addr_t'(REG_PDM0 + 4*c), apb_data_t'(val[c]));
  repeat (2) @(negedge adc_clk_01);
  repeat (PDM_RNG + 1) begin  // one full period
    @(negedge adc_clk_01);
    for (int c = 0; c < 4; c++) cnt[c] += int'(pdm_o[c]);
  end
  for (int c = 0; c < 4; c++) begin
    check_data($sformatf("pdm_o[%0d] ones", c), apb_data_t'(val[c]), apb_data_t'(cnt[c]));
  end
endtask

`default_nettype wire
`endif

//--- tb/adc_top_tb.sv
// ADC sample path testbench
`timescale 1ns/1ps
`default_nettype none

module adc_top_tb import adc_pkg::*; ();

  localparam int CLK_PERIOD = 40;
  localparam int RST_CYCLES = 4;
  localparam int SEED       = 17084;
  // cycles per test in run order, reset first and pdm last
  localparam int RUN_CYCLES    = 20 + 150 + 50 + 70 + 290;
  localparam int MARGIN_CYCLES = 200;

  typedef adc_raw_t [ADC_CHN-1:0] raw_frame_t;  // one raw word per channel

  logic       adc_clk_01 = 1'b0;
  logic       rst_n_i;
  raw_frame_t adc_dat_i;
  logic       psel_i;
  logic       penable_i;
  logic       pwrite_i;
  apb_addr_t  paddr_i;
  apb_data_t  pwdata_i;
  apb_data_t  prdata_o;
  logic       pready_o;
  logic       pslverr_o;
  logic [3:0] pdm_o;

  int n_chk     = 0;
  int n_err_val = 0;  // wrong values
  int n_err_oth = 0;  // anything else

  always #(CLK_PERIOD/2) adc_clk_01 = ~adc_clk_01;

  adc_top dut_i (.*);

  ////////////////////
  // watchdog
  ////////////////////

  initial begin : watchdog
    #((RST_CYCLES + RUN_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
    $display("timeout: tests still running at %0t", $time);
    $display("Test failed");
    $finish;
  end

  ////////////////////
  // main sequence
  ////////////////////

  initial begin : main
    int unused_seed;
    unused_seed = $urandom(SEED);  // seeds the raw samples
    rst_n_i   = 1'b0;
    adc_dat_i = '0;
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
    paddr_i   = '0;
    pwdata_i  = '0;
    repeat (RST_CYCLES) @(negedge adc_clk_01);
    rst_n_i = 1'b1;

    test_reset_values();
    test_capture_order();
    test_level_overflow();
    test_apb_errors();
    test_pdm_density();

    $display("summary: %0d checks, %0d value errors, %0d other errors",
             n_chk, n_err_val, n_err_oth);
    if (n_err_val + n_err_oth == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  `include "adc_tb_tasks.svh"

endmodule

`default_nettype wire

//--- compile.f
+incdir+include
src/adc_pkg.sv
src/adc_capture.sv
src/sample_fifo.sv
src/apb_regs.sv
src/pdm_dac.sv
src/adc_top.sv
tb/adc_top_tb.sv

//--- run.sh
#!/bin/sh
# build and run the ADC sample path testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f \
  --top-module adc_top_tb -o adc_top_tb_sim

out=$(./obj_dir/adc_top_tb_sim) || true
echo "$out"

# only an exact pass line counts as success
echo "$out" | grep -qx "Test completed successfully"
